// File: common/traffic_pkg.sv
`default_nettype none

package traffic_pkg;

	// one received or transmitted byte
	typedef logic [7:0] byte_t;

	// one word on the write port
	typedef logic [31:0] word_t;

	// frame layout is start byte, length byte, then payload
	localparam byte_t START_BYTE = 8'hFF;

	// reply queued once a whole frame has been read ("d")
	localparam byte_t DONE_BYTE = 8'h64;

	// word FIFO between the parser and the write port
	localparam int IN_DEPTH = 64;

	// byte FIFO between the parser and the transmitter
	localparam int OUT_DEPTH = 128;

endpackage

`default_nettype wire

// File: common/fifo_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fifo_if #(
	parameter type payload_t = logic [7:0]
);

	// writer side
	logic push;
	payload_t push_data;

	// reader side, head shown combinationally
	logic pop;
	payload_t pop_data;

	// status from the FIFO
	logic empty;
	logic full;

	modport writer (
		output push,
		output push_data
	);

	modport reader (
		output pop,
		input pop_data,
		input empty
	);

	modport fifo (
		input push,
		input push_data,
		input pop,
		output pop_data,
		output empty,
		output full
	);

endinterface

`default_nettype wire

// File: rtl/fifo/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo
	import traffic_pkg::*;
#(
	parameter type payload_t = byte_t,
	parameter int DEPTH = OUT_DEPTH
) (
	input wire clk,
	input wire reset,
	fifo_if.fifo q
);

	payload_t mem [DEPTH];

	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;

	logic do_push;
	logic do_pop;

	// a push into a full buffer is simply lost
	assign do_push = q.push && !q.full;
	assign do_pop = q.pop && !q.empty;

	assign q.empty = (count == 0);
	assign q.full = (count == DEPTH);

	// head of the queue, valid in the pop cycle
	assign q.pop_data = mem[rd_ptr];

	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= q.push_data;
		end
	end

	// pointers wrap at the last entry
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				if (wr_ptr == DEPTH - 1) begin
					wr_ptr <= '0;
				end else begin
					wr_ptr <= wr_ptr + 1'b1;
				end
			end
			if (do_pop) begin
				if (rd_ptr == DEPTH - 1) begin
					rd_ptr <= '0;
				end else begin
					rd_ptr <= rd_ptr + 1'b1;
				end
			end
		end
	end

	// occupancy, unchanged when push and pop meet
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else begin
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/frame_parser_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module frame_parser_fsm
	import traffic_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire rx_done_tick,
	input wire byte_t rx_data_out,
	input wire frame_done,
	output logic load,
	output logic count_en,
	output byte_t length,
	fifo_if.writer in_q,
	fifo_if.writer out_q
);

	typedef enum logic [1:0] {
		s_idle,
		s_length,
		s_payload
	} state_t;

	state_t state;
	state_t state_next;

	logic start_seen;
	logic frame_end;

	assign start_seen = rx_done_tick && (rx_data_out == START_BYTE);

	// counter has caught up with the length, frame is over
	assign frame_end = (state == s_payload) && frame_done;

	// length byte goes straight to the counter
	assign load = (state == s_length) && rx_done_tick;
	assign length = rx_data_out;

	// payload byte while the frame is still open
	assign count_en = (state == s_payload) && !frame_done && rx_done_tick;

	always_comb begin
		state_next = state;
		case (state)
			s_idle: begin
				if (start_seen) begin
					state_next = s_length;
				end
			end
			s_length: begin
				if (rx_done_tick) begin
					state_next = s_payload;
				end
			end
			s_payload: begin
				// a tick arriving together with frame_end lies outside the frame
				if (frame_done) begin
					state_next = start_seen ? s_length : s_idle;
				end
			end
			default: begin
				state_next = s_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
			in_q.push <= 1'b0;
		end else begin
			state <= state_next;
			in_q.push <= count_en;
		end
	end

	// payload byte zero-extended into a write-port word
	always_ff @(posedge clk) begin
		if (count_en) begin
			in_q.push_data <= word_t'(rx_data_out);
		end
	end

	// one done byte per completed frame, same cycle as the last word push
	assign out_q.push = frame_end;
	assign out_q.push_data = DONE_BYTE;

endmodule

`default_nettype wire

// File: rtl/payload_counter.sv
`timescale 1ns/1ps
`default_nettype none

module payload_counter
	import traffic_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire load,
	input wire byte_t length,
	input wire count_en,
	output logic frame_done
);

	byte_t length_reg;
	byte_t count;

	// length is captured once per frame
	always_ff @(posedge clk) begin
		if (reset) begin
			length_reg <= '0;
		end else if (load) begin
			length_reg <= length;
		end
	end

	// payload bytes seen so far
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			count <= '0;
		end else if (count_en) begin
			count <= count + 1'b1;
		end
	end

	// a zero length is done right after the load
	assign frame_done = (count == length_reg);

endmodule

`default_nettype wire

// File: rtl/stream_drain.sv
`timescale 1ns/1ps
`default_nettype none

module stream_drain #(
	parameter type payload_t = logic [7:0]
) (
	input wire clk,
	input wire reset,
	input wire stall,
	fifo_if.reader q,
	output logic strobe,
	output payload_t data
);

	logic pop;

	// strobe is high exactly one cycle after a pop, so it also
	// marks the previous cycle's pop and keeps a dead cycle between pops.
	// that gap lets the consumer raise its stall level in time
	assign pop = !q.empty && !stall && !strobe;
	assign q.pop = pop;

	always_ff @(posedge clk) begin
		if (reset) begin
			strobe <= 1'b0;
		end else begin
			strobe <= pop;
		end
	end

	// head captured in the pop cycle
	always_ff @(posedge clk) begin
		if (pop) begin
			data <= q.pop_data;
		end
	end

endmodule

`default_nettype wire

// File: rtl/traffic_generator.sv
`timescale 1ns/1ps
`default_nettype none

module traffic_generator
	import traffic_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire rx_done_tick,
	input wire byte_t rx_data_out,
	input wire tx_busy,
	input wire wr_full,
	output logic tx_start_transmission,
	output byte_t tx_data_in,
	output logic wr_en,
	output word_t wr_data
);

	// parser to counter
	logic load;
	logic count_en;
	byte_t length;
	logic frame_done;

	// payload words and done bytes
	fifo_if #(.payload_t(word_t)) in_q ();
	fifo_if #(.payload_t(byte_t)) out_q ();

	frame_parser_fsm parser (
		.clk(clk),
		.reset(reset),
		.rx_done_tick(rx_done_tick),
		.rx_data_out(rx_data_out),
		.frame_done(frame_done),
		.load(load),
		.count_en(count_en),
		.length(length),
		.in_q(in_q),
		.out_q(out_q)
	);

	payload_counter counter (
		.clk(clk),
		.reset(reset),
		.load(load),
		.length(length),
		.count_en(count_en),
		.frame_done(frame_done)
	);

	sync_fifo #(
		.payload_t(word_t),
		.DEPTH(IN_DEPTH)
	) in_fifo (
		.clk(clk),
		.reset(reset),
		.q(in_q)
	);

	sync_fifo #(
		.payload_t(byte_t),
		.DEPTH(OUT_DEPTH)
	) out_fifo (
		.clk(clk),
		.reset(reset),
		.q(out_q)
	);

	// write port held off by wr_full
	stream_drain #(.payload_t(word_t)) wr_drain (
		.clk(clk),
		.reset(reset),
		.stall(wr_full),
		.q(in_q),
		.strobe(wr_en),
		.data(wr_data)
	);

	// transmitter held off by tx_busy
	stream_drain #(.payload_t(byte_t)) tx_drain (
		.clk(clk),
		.reset(reset),
		.stall(tx_busy),
		.q(out_q),
		.strobe(tx_start_transmission),
		.data(tx_data_in)
	);

endmodule

`default_nettype wire

// File: verif/traffic_checker.sv
`timescale 1ns/1ps
`default_nettype none

module traffic_checker
	import traffic_pkg::*;
(
	input wire clk,
	input wire reset,
	input wire rx_done_tick,
	input wire byte_t rx_data_out,
	input wire tx_busy,
	input wire wr_full,
	input wire tx_start_transmission,
	input wire byte_t tx_data_in,
	input wire wr_en,
	input wire word_t wr_data,
	output int mismatch_count,
	output int protocol_count,
	output int pending_count
);

	typedef enum {m_idle, m_length, m_payload} model_state_t;

	model_state_t model_state;
	int frame_len;
	int frame_seen;

	// expected traffic in arrival order
	word_t exp_words [$];
	byte_t exp_dones [$];

	// levels seen one cycle earlier
	logic prev_wr_en;
	logic prev_tx_start;
	logic prev_wr_full;
	logic prev_tx_busy;

	// framing rules applied to one received byte
	task automatic model_byte(input byte_t value);
		case (model_state)
			m_idle: begin
				if (value == START_BYTE) begin
					model_state = m_length;
				end
			end
			m_length: begin
				frame_len = value;
				frame_seen = 0;
				if (frame_len == 0) begin
					exp_dones.push_back(DONE_BYTE);
					model_state = m_idle;
				end else begin
					model_state = m_payload;
				end
			end
			default: begin
				exp_words.push_back({24'h000000, value});
				frame_seen++;
				if (frame_seen == frame_len) begin
					exp_dones.push_back(DONE_BYTE);
					model_state = m_idle;
				end
			end
		endcase
	endtask

	task automatic protocol_error(input string text);
		$display("ERROR at %0t: %s", $time, text);
		protocol_count++;
	endtask

	task automatic check_write();
		word_t expected;
		if (wr_en !== 1'b0 && wr_en !== 1'b1) begin
			protocol_error("wr_en is unknown after reset");
		end else if (wr_en) begin
			if (prev_wr_en) begin
				protocol_error("wr_en was high on two consecutive cycles");
			end
			if (prev_wr_full) begin
				protocol_error("wr_en was issued while wr_full was high");
			end
			if (exp_words.size() == 0) begin
				$display("MISMATCH at %0t: unexpected wr_en with wr_data %h", $time, wr_data);
				mismatch_count++;
			end else begin
				expected = exp_words.pop_front();
				if (wr_data !== expected) begin
					$display("MISMATCH at %0t: wr_data %h, expected %h",
						$time, wr_data, expected);
					mismatch_count++;
				end
			end
		end
	endtask

	task automatic check_tx();
		byte_t expected;
		if (tx_start_transmission !== 1'b0 && tx_start_transmission !== 1'b1) begin
			protocol_error("tx_start_transmission is unknown after reset");
		end else if (tx_start_transmission) begin
			if (prev_tx_start) begin
				protocol_error("tx_start_transmission was high on two consecutive cycles");
			end
			if (prev_tx_busy) begin
				protocol_error("tx_start_transmission was issued while tx_busy was high");
			end
			if (exp_dones.size() == 0) begin
				$display("MISMATCH at %0t: unexpected tx_start_transmission with %h",
					$time, tx_data_in);
				mismatch_count++;
			end else begin
				expected = exp_dones.pop_front();
				if (tx_data_in !== expected) begin
					$display("MISMATCH at %0t: tx_data_in %h, expected %h",
						$time, tx_data_in, expected);
					mismatch_count++;
				end
			end
		end
	endtask

	// sampled mid-cycle where inputs and outputs are settled
	always @(negedge clk) begin
		if (reset) begin
			model_state = m_idle;
			exp_words.delete();
			exp_dones.delete();
			prev_wr_en = 1'b0;
			prev_tx_start = 1'b0;
			prev_wr_full = 1'b0;
			prev_tx_busy = 1'b0;
			mismatch_count = 0;
			protocol_count = 0;
		end else begin
			if (rx_done_tick === 1'b1) begin
				model_byte(rx_data_out);
			end
			check_write();
			check_tx();
			prev_wr_en = (wr_en === 1'b1);
			prev_tx_start = (tx_start_transmission === 1'b1);
			prev_wr_full = wr_full;
			prev_tx_busy = tx_busy;
		end
		pending_count = exp_words.size() + exp_dones.size();
	end

endmodule

`default_nettype wire

// File: verif/tb_traffic_generator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_traffic_generator
	import traffic_pkg::*;
();

	typedef struct packed {
		logic framed;
		int len;
		byte_t start;
		int wr_hold;
		int tx_hold;
		int exp_words;
		int exp_dones;
	} entry_t;

	localparam int NUM_ENTRIES = 10;

	// framed, length, first payload value, wr_full hold, tx_busy hold,
	// expected words, expected done bytes
	// the long tx_busy hold of the empty frame spans the next frame's done byte
	entry_t entries [NUM_ENTRIES] = '{
		'{1'b0, 3, 8'h10, 0, 0, 0, 0},
		'{1'b1, 4, 8'h01, 0, 0, 4, 1},
		'{1'b1, 0, 8'h00, 0, OUT_DEPTH / 2, 0, 1},
		'{1'b0, 2, 8'h80, 0, 0, 0, 0},
		'{1'b1, 1, 8'hA5, 0, 3, 1, 1},
		'{1'b1, 60, 8'hC8, IN_DEPTH - 24, OUT_DEPTH / 8, 60, 1},
		'{1'b1, 8, 8'h30, 5, 2, 8, 1},
		'{1'b1, 0, 8'h00, 3, 0, 0, 1},
		'{1'b1, 16, 8'hF0, 0, 20, 16, 1},
		'{1'b0, 1, 8'h64, 0, 0, 0, 0}
	};

	logic clk;
	logic reset;
	logic rx_done_tick;
	byte_t rx_data_out;
	logic tx_busy;
	logic wr_full;
	logic tx_start_transmission;
	byte_t tx_data_in;
	logic wr_en;
	word_t wr_data;

	int mismatch_count;
	int protocol_count;
	int pending;
	int table_errors = 0;
	int wr_seen = 0;
	int done_seen = 0;
	int tx_hold = 0;

	traffic_generator traffic_generator_inst (
		.clk(clk),
		.reset(reset),
		.rx_done_tick(rx_done_tick),
		.rx_data_out(rx_data_out),
		.tx_busy(tx_busy),
		.wr_full(wr_full),
		.tx_start_transmission(tx_start_transmission),
		.tx_data_in(tx_data_in),
		.wr_en(wr_en),
		.wr_data(wr_data)
	);

	traffic_checker traffic_checker_inst (
		.clk(clk),
		.reset(reset),
		.rx_done_tick(rx_done_tick),
		.rx_data_out(rx_data_out),
		.tx_busy(tx_busy),
		.wr_full(wr_full),
		.tx_start_transmission(tx_start_transmission),
		.tx_data_in(tx_data_in),
		.wr_en(wr_en),
		.wr_data(wr_data),
		.mismatch_count(mismatch_count),
		.protocol_count(protocol_count),
		.pending_count(pending)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// inputs move a little after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic send_byte(input byte_t value);
		int gap;
		rx_data_out = value;
		rx_done_tick = 1'b1;
		next_cycle();
		rx_done_tick = 1'b0;
		gap = $urandom % 4;
		repeat (gap) begin
			next_cycle();
		end
	endtask

	task automatic send_entry(input entry_t entry);
		int k;
		if (entry.framed) begin
			send_byte(START_BYTE);
			send_byte(byte_t'(entry.len));
		end
		for (k = 0; k < entry.len; k++) begin
			send_byte(byte_t'(entry.start + k));
		end
	endtask

	task automatic hold_wr_full(input int cycles);
		if (cycles > 0) begin
			wr_full = 1'b1;
			repeat (cycles) begin
				next_cycle();
			end
			wr_full = 1'b0;
		end
	endtask

	function automatic int timeout_cycles();
		int total;
		total = 500;
		foreach (entries[i]) begin
			total += (entries[i].len + (entries[i].framed ? 2 : 0)) * 8;
			total += entries[i].wr_hold + entries[i].tx_hold;
		end
		return total;
	endfunction

	// transmitter model, busy from the cycle after each start
	initial begin
		int hold;
		tx_busy = 1'b0;
		forever begin
			@(negedge clk);
			if (tx_start_transmission === 1'b1 && tx_hold > 0) begin
				hold = tx_hold;
				next_cycle();
				tx_busy = 1'b1;
				repeat (hold) begin
					next_cycle();
				end
				tx_busy = 1'b0;
			end
		end
	end

	// strobe counts per table entry
	always @(negedge clk) begin
		if (!reset) begin
			if (wr_en === 1'b1) begin
				wr_seen++;
			end
			if (tx_start_transmission === 1'b1) begin
				done_seen++;
			end
		end
	end

	initial begin
		int limit;
		limit = timeout_cycles();
		repeat (limit) @(posedge clk);
		$display("ERROR: run timed out after %0d cycles with %0d entries pending", limit, pending);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		int seed_value;
		int wr_base;
		int done_base;
		int total_errors;
		reset = 1'b1;
		rx_done_tick = 1'b0;
		rx_data_out = '0;
		wr_full = 1'b0;
		seed_value = $urandom(32'h923ee143);
		repeat (16) @(posedge clk);
		#2;
		reset = 1'b0;
		// quiet stretch before the first byte
		repeat (10) begin
			next_cycle();
		end
		foreach (entries[i]) begin
			wr_base = wr_seen;
			done_base = done_seen;
			tx_hold = entries[i].tx_hold;
			fork
				send_entry(entries[i]);
				hold_wr_full(entries[i].wr_hold);
			join
			while (pending != 0) begin
				next_cycle();
			end
			if (wr_seen - wr_base != entries[i].exp_words) begin
				$display("MISMATCH at %0t: entry %0d gave %0d words, expected %0d",
					$time, i, wr_seen - wr_base, entries[i].exp_words);
				table_errors++;
			end
			if (done_seen - done_base != entries[i].exp_dones) begin
				$display("MISMATCH at %0t: entry %0d gave %0d done bytes, expected %0d",
					$time, i, done_seen - done_base, entries[i].exp_dones);
				table_errors++;
			end
		end
		// late stray output would still show up here
		repeat (20) begin
			next_cycle();
		end
		total_errors = mismatch_count + protocol_count + table_errors + pending;
		$display("errors: %0d mismatches, %0d protocol, %0d entry counts, %0d expected left",
			mismatch_count, protocol_count, table_errors, pending);
		if (total_errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: list.f
common/traffic_pkg.sv
common/fifo_if.sv
rtl/fifo/sync_fifo.sv
rtl/frame_parser_fsm.sv
rtl/payload_counter.sv
rtl/stream_drain.sv
rtl/traffic_generator.sv
verif/traffic_checker.sv
verif/tb_traffic_generator.sv
